/* hdl/adc_pkg.sv */
package adc_pkg;

	// ==============================
	// Converter sizes
	// ==============================

	// LTC2308 result width and input count
	localparam int ADC_DATA_W = 12;
	localparam int ADC_CH_W = 3;
	localparam int ADC_NUM_CH = 8;

	// Configuration word length on SDI
	localparam int ADC_CFG_BITS = 6;

	// One conversion result and its channel
	typedef logic [ADC_DATA_W-1:0] adc_data_t;
	typedef logic [ADC_CH_W-1:0] adc_ch_t;

	// ==============================
	// SPI timing in clock cycles
	// ==============================

	// CONVST to CONVST spacing, raise for slower sampling on hardware
	localparam int SAMPLE_PERIOD = 400;
	// CONVST high time plus conversion time before the first SCK
	localparam int CONV_WAIT = 90;
	// CONVST pulse width
	localparam int CONVST_HIGH = 2;
	// Clocks per SCK half period
	localparam int SCK_HALF = 1;

	// Counter widths derived from the timing above
	localparam int PERIOD_W = $clog2(SAMPLE_PERIOD);
	localparam int HALF_W = $clog2(SCK_HALF + 1);
	localparam int BIT_W = $clog2(ADC_DATA_W + 1);

	// Single-ended unipolar word, bits S/D O/S S1 S0 UNI SLP
	// Odd channels set O/S, S1 S0 pick the pair
	function automatic logic [ADC_CFG_BITS-1:0] adc_cfg_word(input adc_ch_t ch);
		return {1'b1, ch[0], ch[2], ch[1], 1'b1, 1'b0};
	endfunction

endpackage

/* hdl/report_pkg.sv */
package report_pkg;

	// ==============================
	// Message bytes
	// ==============================

	// One ASCII character on the byte port
	typedef logic [7:0] msg_byte_t;

	// "chN=0xHHHH" plus CR LF
	localparam int MSG_LEN = 12;
	localparam int MSG_IDX_W = $clog2(MSG_LEN);
	typedef logic [MSG_IDX_W-1:0] msg_idx_t;

	// Fixed text of every line
	localparam msg_byte_t CHAR_LOWER_C = "c";
	localparam msg_byte_t CHAR_LOWER_H = "h";
	localparam msg_byte_t CHAR_EQUAL = "=";
	localparam msg_byte_t CHAR_ZERO = "0";
	localparam msg_byte_t CHAR_LOWER_X = "x";
	// Base of the upper-case hex letters
	localparam msg_byte_t CHAR_UPPER_A = "A";

	// Line ending
	localparam msg_byte_t CHAR_CR = 8'h0D;
	localparam msg_byte_t CHAR_LF = 8'h0A;

	// ==============================
	// Credit flow control
	// ==============================

	localparam int CREDIT_W = 3;
	typedef logic [CREDIT_W-1:0] credit_cnt_t;

	// Bytes the sink can buffer
	localparam credit_cnt_t TX_CREDITS_INIT = 3'd4;

endpackage

/* hdl/ltc2308_sampler.sv */
`timescale 1ns/10ps

module ltc2308_sampler import adc_pkg::*; (
	input  logic      pll0_clock0,
	input  logic      master_reset_n,
	input  logic      sdo,
	output logic      convst,
	output logic      sck,
	output logic      sdi,
	output logic      sample_valid,
	output adc_data_t sample_data,
	output adc_ch_t   sample_ch
);

	// Sample period position
	logic [PERIOD_W-1:0] period_cnt;
	// Frame shift state
	logic shifting;
	logic [HALF_W-1:0] half_cnt;
	logic [BIT_W-1:0] fall_cnt;
	logic frame_start;
	logic sck_edge;
	// High for one clock after the last SCK fall
	logic frame_end;
	// Config bits still to go out, MSB on SDI
	logic [ADC_CFG_BITS-1:0] cfg_sr;
	// Bits collected from SDO
	adc_data_t data_sr;
	// Channel requested now and channel whose data comes back now
	adc_ch_t send_ch;
	adc_ch_t data_ch;
	// First frame returns stale data
	logic have_prev;

	// ==============================
	// Conversion start
	// ==============================

	assign frame_start = (period_cnt == PERIOD_W'(CONV_WAIT));

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			period_cnt <= '0;
			convst <= 1'b0;
		end else begin
			// Free running period counter
			if (period_cnt == PERIOD_W'(SAMPLE_PERIOD - 1)) begin
				period_cnt <= '0;
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
			// CONVST pulse at the top of each period
			if (period_cnt == '0) begin
				convst <= 1'b1;
			end else if (period_cnt == PERIOD_W'(CONVST_HIGH)) begin
				convst <= 1'b0;
			end
		end
	end

	// ==============================
	// SPI shift sequence
	// ==============================

	// SCK toggles when the half period count runs out
	assign sck_edge = shifting && (half_cnt == HALF_W'(SCK_HALF - 1));

	// SDI shows the top config bit, zero once the word is out
	assign sdi = cfg_sr[ADC_CFG_BITS-1];

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			shifting <= 1'b0;
			sck <= 1'b0;
			half_cnt <= '0;
			fall_cnt <= '0;
			cfg_sr <= '0;
			frame_end <= 1'b0;
		end else begin
			frame_end <= 1'b0;
			if (frame_start) begin
				// Conversion done, first config bit set up before SCK rises
				shifting <= 1'b1;
				half_cnt <= '0;
				fall_cnt <= '0;
				cfg_sr <= adc_cfg_word(send_ch);
			end else if (shifting) begin
				if (sck_edge) begin
					half_cnt <= '0;
					sck <= ~sck;
					if (sck) begin
						// Falling edge, next config bit out
						cfg_sr <= cfg_sr << 1;
						fall_cnt <= fall_cnt + 1'b1;
						// Twelve SCK periods per frame
						if (fall_cnt == BIT_W'(ADC_DATA_W - 1)) begin
							shifting <= 1'b0;
							frame_end <= 1'b1;
						end
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

	// SDO sampled as SCK rises, MSB first
	always_ff @(posedge pll0_clock0) begin
		if (sck_edge && !sck) begin
			data_sr <= {data_sr[ADC_DATA_W-2:0], sdo};
		end
	end

	// ==============================
	// Channel rotation and result
	// ==============================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			send_ch <= '0;
			data_ch <= '0;
			have_prev <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			// Pulse only for frames that carry a configured result
			sample_valid <= frame_end && have_prev;
			if (frame_end) begin
				have_prev <= 1'b1;
				// Data of the next frame belongs to the channel just sent
				data_ch <= send_ch;
				if (send_ch == adc_ch_t'(ADC_NUM_CH - 1)) begin
					send_ch <= '0;
				end else begin
					send_ch <= send_ch + 1'b1;
				end
			end
		end
	end

	// Result and label held until the next frame ends
	always_ff @(posedge pll0_clock0) begin
		if (frame_end) begin
			sample_data <= data_sr;
			sample_ch <= data_ch;
		end
	end

endmodule

/* hdl/report_formatter.sv */
`timescale 1ns/10ps

module report_formatter import adc_pkg::*, report_pkg::*; (
	input  logic      pll0_clock0,
	input  logic      master_reset_n,
	input  logic      sample_valid,
	input  adc_data_t sample_data,
	input  adc_ch_t   sample_ch,
	input  logic      port_ready,
	output logic      fmt_valid,
	output msg_byte_t fmt_byte
);

	// Pending slot, newest sample wins
	logic pend_valid;
	adc_data_t pend_data;
	adc_ch_t pend_ch;
	// Line being sent
	adc_data_t cur_data;
	adc_ch_t cur_ch;
	msg_idx_t idx;
	// Handshake with the byte port
	logic accept;
	logic line_done;
	logic load;

	// Nibble to upper-case hex character
	function automatic msg_byte_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return CHAR_ZERO + msg_byte_t'(nib);
		end
		return CHAR_UPPER_A + msg_byte_t'(nib - 4'd10);
	endfunction

	// ==============================
	// Line control
	// ==============================

	assign accept = fmt_valid && port_ready;
	assign line_done = accept && (idx == msg_idx_t'(MSG_LEN - 1));
	// New line starts when idle or right after the line feed
	assign load = (!fmt_valid || line_done) && (pend_valid || sample_valid);

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			fmt_valid <= 1'b0;
			idx <= '0;
			pend_valid <= 1'b0;
		end else begin
			if (load) begin
				fmt_valid <= 1'b1;
				idx <= '0;
				// Slot drained, refilled only by a sample in this cycle
				pend_valid <= pend_valid && sample_valid;
			end else begin
				if (line_done) begin
					fmt_valid <= 1'b0;
				end else if (accept) begin
					idx <= idx + 1'b1;
				end
				// Sample arriving mid line waits in the slot
				if (sample_valid) begin
					pend_valid <= 1'b1;
				end
			end
		end
	end

	// Slot takes every sample, only pend_valid says it counts
	always_ff @(posedge pll0_clock0) begin
		if (sample_valid) begin
			pend_data <= sample_data;
			pend_ch <= sample_ch;
		end
	end

	// Older pending sample goes first
	always_ff @(posedge pll0_clock0) begin
		if (load) begin
			cur_data <= pend_valid ? pend_data : sample_data;
			cur_ch <= pend_valid ? pend_ch : sample_ch;
		end
	end

	// ==============================
	// Character select
	// ==============================

	always_comb begin
		case (idx)
			4'd0: fmt_byte = CHAR_LOWER_C;
			4'd1: fmt_byte = CHAR_LOWER_H;
			// Channel digit
			4'd2: fmt_byte = CHAR_ZERO + msg_byte_t'(cur_ch);
			4'd3: fmt_byte = CHAR_EQUAL;
			4'd4: fmt_byte = CHAR_ZERO;
			4'd5: fmt_byte = CHAR_LOWER_X;
			// Four hex digits, top one always 0
			4'd6: fmt_byte = CHAR_ZERO;
			4'd7: fmt_byte = hex_char(cur_data[11:8]);
			4'd8: fmt_byte = hex_char(cur_data[7:4]);
			4'd9: fmt_byte = hex_char(cur_data[3:0]);
			4'd10: fmt_byte = CHAR_CR;
			default: fmt_byte = CHAR_LF;
		endcase
	end

endmodule

/* hdl/credit_byte_port.sv */
`timescale 1ns/10ps

module credit_byte_port import report_pkg::*; (
	input  logic      pll0_clock0,
	input  logic      master_reset_n,
	input  logic      fmt_valid,
	input  msg_byte_t fmt_byte,
	input  logic      credit_return,
	output logic      port_ready,
	output logic      tx_valid,
	output msg_byte_t tx_byte
);

	// Free slots at the sink, charged in the tx_valid cycle
	credit_cnt_t credit_cnt;
	logic accept;

	// ==============================
	// Credit check
	// ==============================

	// Byte in flight on tx already owns one credit
	assign port_ready = (credit_cnt > credit_cnt_t'(tx_valid));
	assign accept = fmt_valid && port_ready;

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			credit_cnt <= TX_CREDITS_INIT;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= accept;
			// Use and return together leave the count unchanged
			case ({tx_valid, credit_return})
				2'b10: credit_cnt <= credit_cnt - credit_cnt_t'(1);
				2'b01: credit_cnt <= credit_cnt + credit_cnt_t'(1);
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Output byte register
	always_ff @(posedge pll0_clock0) begin
		if (accept) begin
			tx_byte <= fmt_byte;
		end
	end

endmodule

/* hdl/adc_report_top.sv */
`timescale 1ns/10ps

module adc_report_top import adc_pkg::*, report_pkg::*; (
	input  logic      pll0_clock0,
	input  logic      master_reset_n,
	input  logic      adc_sdo,
	input  logic      credit_return,
	output logic      adc_convst,
	output logic      adc_sck,
	output logic      adc_sdi,
	output logic      tx_valid,
	output msg_byte_t tx_byte
);

	// Sampler to formatter
	logic sample_valid;
	adc_data_t sample_data;
	adc_ch_t sample_ch;
	// Formatter to byte port
	logic fmt_valid;
	msg_byte_t fmt_byte;
	logic port_ready;

	// ==============================
	// LTC2308 SPI side
	// ==============================

	ltc2308_sampler u_sampler (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.sdo            (adc_sdo),
		.convst         (adc_convst),
		.sck            (adc_sck),
		.sdi            (adc_sdi),
		.sample_valid   (sample_valid),
		.sample_data    (sample_data),
		.sample_ch      (sample_ch)
	);

	// Text line per sample
	report_formatter u_formatter (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.sample_valid   (sample_valid),
		.sample_data    (sample_data),
		.sample_ch      (sample_ch),
		.port_ready     (port_ready),
		.fmt_valid      (fmt_valid),
		.fmt_byte       (fmt_byte)
	);

	// Credit flow control toward the sink
	credit_byte_port u_port (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.fmt_valid      (fmt_valid),
		.fmt_byte       (fmt_byte),
		.credit_return  (credit_return),
		.port_ready     (port_ready),
		.tx_valid       (tx_valid),
		.tx_byte        (tx_byte)
	);

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic pll0_clock0,
	output logic master_reset_n
);

	// Free running clock, low for the first half period
	initial begin
		pll0_clock0 = 1'b0;
		forever begin
			#(PERIOD_NS / 2) pll0_clock0 = ~pll0_clock0;
		end
	end

	// Reset low for the first cycles, released on a rising edge
	initial begin
		master_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge pll0_clock0);
		master_reset_n <= 1'b1;
	end

endmodule

/* test/adc_report_chk.sv */
`timescale 1ns/10ps

module adc_report_chk import report_pkg::*; (
	input logic        pll0_clock0,
	input logic        master_reset_n,
	input logic        tx_valid,
	input credit_cnt_t credit_cnt,
	input logic        convst,
	input logic        sck
);

	// ==============================
	// Credit rule on the byte port
	// ==============================

	// A byte on tx always owns a credit
	tx_needs_credit: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		!(tx_valid && (credit_cnt == '0)))
		else $error("tx_valid high while the credit count is zero");

	// Returns never push the count past the sink size
	credit_bounded: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		credit_cnt <= TX_CREDITS_INIT)
		else $error("Credit count %0d above the sink size", credit_cnt);

	// ==============================
	// SPI pins
	// ==============================

	// No clocking while a conversion is being started
	sck_idle_in_convst: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		convst |-> !sck)
		else $error("SCK high while CONVST is high");

endmodule

// Byte port instance, SPI inputs tied idle
bind credit_byte_port adc_report_chk u_credit_chk (
	.pll0_clock0    (pll0_clock0),
	.master_reset_n (master_reset_n),
	.tx_valid       (tx_valid),
	.credit_cnt     (credit_cnt),
	.convst         (1'b0),
	.sck            (1'b0)
);

// Sampler instance, credit inputs tied idle
bind ltc2308_sampler adc_report_chk u_spi_chk (
	.pll0_clock0    (pll0_clock0),
	.master_reset_n (master_reset_n),
	.tx_valid       (1'b0),
	.credit_cnt     ('0),
	.convst         (convst),
	.sck            (sck)
);

/* test/adc_report_tb.sv */
`timescale 1ns/10ps

module adc_report_tb import adc_pkg::*, report_pkg::*; ();

	// ==============================
	// Run length and stimulus setup
	// ==============================

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int TOTAL_LINES = 40;
	// Stall starts once this many lines are checked
	localparam int STALL_AFTER_LINES = 16;
	localparam int STALL_CYCLES = 3000 / CLK_PERIOD;
	// Sixty sample periods plus stall and a margin
	localparam int WATCHDOG_NS = ((TOTAL_LINES + 20) * SAMPLE_PERIOD + STALL_CYCLES + 500)
		* CLK_PERIOD;
	localparam logic [15:0] LFSR_SEED = 16'd56291;

	// One text line, byte 0 in the top bits
	typedef logic [8*MSG_LEN-1:0] line_t;

	logic pll0_clock0;
	logic master_reset_n;
	logic adc_sdo = 1'b0;
	logic credit_return = 1'b0;
	logic adc_convst;
	logic adc_sck;
	logic adc_sdi;
	logic tx_valid;
	msg_byte_t tx_byte;

	// Converter model state
	logic [15:0] value_lfsr = LFSR_SEED;
	logic [15:0] value_draw;
	logic prev_convst = 1'b0;
	logic prev_sck = 1'b0;
	adc_data_t frame_value = '0;
	int sdo_bit = 0;
	logic [ADC_CFG_BITS-1:0] cfg_word = '0;
	int cfg_bits = 0;
	adc_ch_t req_ch = '0;
	adc_ch_t next_req = '0;
	logic have_req = 1'b0;
	// Clock count of the model and of the last CONVST rise
	int model_cycle = 0;
	int last_convst = -1;
	// Expected results in output order
	adc_ch_t exp_ch_q[$];
	adc_data_t exp_val_q[$];

	// Credit sink state
	logic [15:0] delay_lfsr = LFSR_SEED;
	logic [15:0] delay_draw;
	logic stall = 1'b0;
	int sink_cycle = 0;
	int sink_held = 0;
	int due_q[$];

	// Line collection and results
	msg_byte_t line_buf[MSG_LEN];
	int line_len = 0;
	adc_ch_t next_label = '0;
	logic skip_window = 1'b0;
	int post_stall_lines = 0;
	int lines_checked = 0;
	int skipped = 0;
	int value_errors = 0;
	int other_errors = 0;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n)
	);

	adc_report_top UUT (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.adc_sdo        (adc_sdo),
		.credit_return  (credit_return),
		.adc_convst     (adc_convst),
		.adc_sck        (adc_sck),
		.adc_sdi        (adc_sdi),
		.tx_valid       (tx_valid),
		.tx_byte        (tx_byte)
	);

	// ==============================
	// Random source and reference
	// ==============================

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(inout logic [15:0] state, input int count, output logic [15:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			state = lfsr_next(state);
			bits = {bits[14:0], state[0]};
		end
	endtask

	function automatic msg_byte_t hex_digit(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return msg_byte_t'("0" + nib);
		end
		return msg_byte_t'("A" + nib - 4'd10);
	endfunction

	// Text back to a nibble, bad characters give 0
	function automatic logic [3:0] hex_nibble(input msg_byte_t c);
		if (c >= "0" && c <= "9") begin
			return 4'(c - "0");
		end
		if (c >= "A" && c <= "F") begin
			return 4'(c - "A" + 8'd10);
		end
		return 4'h0;
	endfunction

	// "chN=0x0HHH" then CR LF
	function automatic line_t expected_line(input adc_ch_t ch, input adc_data_t val);
		line_t line;
		line = {"ch", msg_byte_t'("0" + ch), "=0x", "0", hex_digit(val[11:8]),
			hex_digit(val[7:4]), hex_digit(val[3:0]), 8'h0D, 8'h0A};
		return line;
	endfunction

	// ==============================
	// Compare tasks
	// ==============================

	task automatic check_byte(input string name, input msg_byte_t got, input msg_byte_t want);
		if (got !== want) begin
			value_errors++;
			$display("FAIL %0t ns %s got 0x%02h expected 0x%02h", $time, name, got, want);
		end
	endtask

	task automatic check_channel(input string name, input adc_ch_t got, input adc_ch_t want);
		if (got !== want) begin
			value_errors++;
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_value(input string name, input adc_data_t got, input adc_data_t want);
		if (got !== want) begin
			value_errors++;
			$display("FAIL %0t ns %s got 0x%03h expected 0x%03h", $time, name, got, want);
		end
	endtask

	// S/D O/S S1 S0 UNI SLP, channel is S1 S0 O/S
	task automatic decode_config(input logic [ADC_CFG_BITS-1:0] word);
		adc_ch_t ch;
		ch = {word[3], word[2], word[4]};
		if (word[5] !== 1'b1 || word[1] !== 1'b1 || word[0] !== 1'b0) begin
			other_errors++;
			$display("Config word %b at %0t ns is not single-ended unipolar awake", word, $time);
		end
		check_channel("adc_sdi channel", ch, next_req);
		req_ch = ch;
		have_req = 1'b1;
		next_req = next_req + 1'b1;
	endtask

	task automatic check_line();
		adc_ch_t got_ch;
		adc_data_t got_val;
		adc_ch_t want_ch;
		adc_data_t want_val;
		line_t want_line;
		int skipped_here;
		int i;
		skipped_here = 0;
		if (line_len != MSG_LEN) begin
			other_errors++;
			$display("Line of %0d bytes ended at %0t ns instead of %0d", line_len, $time, MSG_LEN);
			return;
		end
		got_ch = adc_ch_t'(line_buf[2] - "0");
		got_val = {hex_nibble(line_buf[7]), hex_nibble(line_buf[8]), hex_nibble(line_buf[9])};
		if (exp_ch_q.size() == 0) begin
			other_errors++;
			$display("Line for channel %0d at %0t ns with no sample expected", got_ch, $time);
			return;
		end
		// Samples overwritten under back-pressure
		if (skip_window) begin
			while (exp_ch_q.size() > 1 && (exp_ch_q[0] != got_ch || exp_val_q[0] != got_val)) begin
				void'(exp_ch_q.pop_front());
				void'(exp_val_q.pop_front());
				skipped_here++;
			end
		end
		want_ch = exp_ch_q.pop_front();
		want_val = exp_val_q.pop_front();
		want_line = expected_line(want_ch, want_val);
		for (i = 0; i < MSG_LEN; i++) begin
			check_byte($sformatf("tx_byte[%0d]", i), line_buf[i],
				want_line[8*(MSG_LEN-1-i) +: 8]);
		end
		check_channel("line channel", got_ch, want_ch);
		check_value("line value", got_val, want_val);
		// Label rotation, broken only by an allowed skip
		if (skipped_here == 0) begin
			check_channel("line channel order", got_ch, next_label);
		end
		skipped += skipped_here;
		next_label = got_ch + 1'b1;
		lines_checked++;
		if (skip_window && !stall) begin
			post_stall_lines++;
			if (post_stall_lines >= 2) begin
				skip_window = 1'b0;
			end
		end
	endtask

	// ==============================
	// LTC2308 model
	// ==============================

	// Pin values read here are the ones held through the past cycle
	always @(posedge pll0_clock0) begin
		model_cycle++;
		// CONVST rose, new result ready for this frame
		if (adc_convst && !prev_convst) begin
			// Conversions start one sample period apart
			if (last_convst >= 0 && model_cycle - last_convst != SAMPLE_PERIOD) begin
				value_errors++;
				$display("FAIL %0t ns adc_convst period got %0d expected %0d", $time,
					model_cycle - last_convst, SAMPLE_PERIOD);
			end
			last_convst = model_cycle;
			draw_bits(value_lfsr, ADC_DATA_W, value_draw);
			frame_value = value_draw[ADC_DATA_W-1:0];
			// Data belongs to the channel sent one frame earlier
			if (have_req) begin
				exp_ch_q.push_back(req_ch);
				exp_val_q.push_back(frame_value);
			end
			sdo_bit = ADC_DATA_W - 1;
			adc_sdo <= frame_value[ADC_DATA_W-1];
			cfg_bits = 0;
			cfg_word = '0;
		end
		// SCK rose last edge, SDI holds a config bit
		if (adc_sck && !prev_sck && cfg_bits < ADC_CFG_BITS) begin
			cfg_word = {cfg_word[ADC_CFG_BITS-2:0], adc_sdi};
			cfg_bits++;
			if (cfg_bits == ADC_CFG_BITS) begin
				decode_config(cfg_word);
			end
		end
		// SCK falls at this edge, next SDO bit
		if (adc_sck && sdo_bit > 0) begin
			sdo_bit--;
			adc_sdo <= frame_value[sdo_bit];
		end
		prev_convst = adc_convst;
		prev_sck = adc_sck;
	end

	// ==============================
	// Credit sink
	// ==============================

	always @(posedge pll0_clock0) begin
		sink_cycle++;
		if (tx_valid) begin
			sink_held++;
			if (sink_held > TX_CREDITS_INIT) begin
				other_errors++;
				$display("Sink holds %0d bytes at %0t ns, more than its %0d slots",
					sink_held, $time, TX_CREDITS_INIT);
			end
			draw_bits(delay_lfsr, 4, delay_draw);
			due_q.push_back(sink_cycle + int'(delay_draw[3:0]));
		end
		// At most one credit back per cycle, none while stalled
		if (!stall && due_q.size() > 0 && due_q[0] <= sink_cycle) begin
			void'(due_q.pop_front());
			sink_held--;
			credit_return <= 1'b1;
		end else begin
			credit_return <= 1'b0;
		end
	end

	// ==============================
	// Line collection and compare
	// ==============================

	always @(posedge pll0_clock0) begin
		if (stall) begin
			skip_window = 1'b1;
			post_stall_lines = 0;
		end
		if (tx_valid) begin
			if (line_len < MSG_LEN) begin
				line_buf[line_len] = tx_byte;
			end
			line_len++;
			// Line feed closes the line
			if (tx_byte == 8'h0A) begin
				check_line();
				line_len = 0;
			end else if (line_len > MSG_LEN) begin
				other_errors++;
				$display("No line feed within %0d bytes at %0t ns", MSG_LEN, $time);
				line_len = 0;
			end
		end
	end

	task automatic wait_lines(input int count);
		while (lines_checked < count) begin
			@(negedge pll0_clock0);
		end
	endtask

	// ==============================
	// Test sequence and watchdog
	// ==============================

	initial begin
		// Times print as whole nanoseconds
		$timeformat(-9, 0, "", 0);
		wait_lines(STALL_AFTER_LINES);
		// Stall once a line is under way
		while (line_len < 2) begin
			@(negedge pll0_clock0);
		end
		@(posedge pll0_clock0);
		stall <= 1'b1;
		repeat (STALL_CYCLES) @(posedge pll0_clock0);
		stall <= 1'b0;
		wait_lines(TOTAL_LINES);
		$display("Lines checked %0d, value errors %0d, other errors %0d, skipped across stall %0d",
			lines_checked, value_errors, other_errors, skipped);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d of %0d lines checked",
			WATCHDOG_NS, lines_checked, TOTAL_LINES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* all.f */
hdl/adc_pkg.sv
hdl/report_pkg.sv
hdl/ltc2308_sampler.sv
hdl/report_formatter.sv
hdl/credit_byte_port.sv
hdl/adc_report_top.sv
test/tb_clock_gen.sv
test/adc_report_chk.sv
test/adc_report_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

TOP=adc_report_tb
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module "$TOP" -f all.f -o "$TOP" \
	&& { "./obj_dir/$TOP" > "$LOG" 2>&1; cat "$LOG"; } \
	|| { echo "Verilator build failed"; exit 1; }

grep -qF '*** TEST PASSED ***' "$LOG" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see $LOG"; exit 1; }
